// File: include/scroll_cfg.svh
`ifndef SCROLL_CFG_SVH
`define SCROLL_CFG_SVH

// Default visible window
`define IMG_WIDTH_DEF 640
`define IMG_HEIGHT_DEF 480

// Words per read burst
// Window width must be a multiple of it
`define BURST_LEN 8

`define FIFO_DEPTH 16

// Cycles of stable PLL lock before fetching may begin
`define INIT_CYCLES_DEF 33550

`define BG_BASE_ADDR 32'h0

`endif

// File: src/scroll_pkg.sv
`default_nettype none

package scroll_pkg;

  typedef struct packed {
    logic        write;
    logic [2:0]  address;
    logic [31:0] writedata;
  } csr_wr_t;

  typedef struct packed {
    logic [15:0] bg_width;
    logic [15:0] bg_height;
    logic [15:0] offset_x;
    logic [15:0] offset_y;
    logic        start;
  } cfg_regs_t;

  // Byte address, fixed-length burst
  typedef struct packed {
    logic        read;
    logic [31:0] address;
    logic [4:0]  burstcount;
  } avm_cmd_t;

  typedef struct packed {
    logic        waitrequest;
    logic        readdatavalid;
    logic [31:0] readdata;
  } avm_rsp_t;

endpackage

`default_nettype wire

// File: src/scroll_regs.sv
`default_nettype none

module scroll_regs (
  input  wire                  clk,
  input  wire                  reset_n,
  input  wire scroll_pkg::csr_wr_t csr,
  output scroll_pkg::cfg_regs_t    cfg
);

  import scroll_pkg::*;

  localparam logic [2:0] ADDR_BG_WIDTH  = 3'd0;
  localparam logic [2:0] ADDR_BG_HEIGHT = 3'd1;
  localparam logic [2:0] ADDR_OFFSET_X  = 3'd2;
  localparam logic [2:0] ADDR_OFFSET_Y  = 3'd3;
  localparam logic [2:0] ADDR_START     = 3'd4;

  cfg_regs_t cfg_q;

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      cfg_q <= '0;
    end else if (csr.write) begin
      case (csr.address)
        ADDR_BG_WIDTH: begin
          cfg_q.bg_width <= csr.writedata[15:0];
        end
        ADDR_BG_HEIGHT: begin
          cfg_q.bg_height <= csr.writedata[15:0];
        end
        ADDR_OFFSET_X: begin
          cfg_q.offset_x <= csr.writedata[15:0];
        end
        ADDR_OFFSET_Y: begin
          cfg_q.offset_y <= csr.writedata[15:0];
        end
        ADDR_START: begin
          // Sticky until reset
          if (csr.writedata[0]) begin
            cfg_q.start <= 1'b1;
          end
        end
        default: begin
        end
      endcase
    end
  end

  assign cfg = cfg_q;

  // Registers only move on the cycle after a strobe
  cfg_stable_without_write: assert property (
    @(posedge clk) disable iff (!reset_n)
    !$past(csr.write) |-> $stable(cfg)
  );

endmodule

`default_nettype wire

// File: src/viewport_addr_gen.sv
`default_nettype none

`include "scroll_cfg.svh"

module viewport_addr_gen #(
  parameter int IMG_WIDTH  = `IMG_WIDTH_DEF,
  parameter int IMG_HEIGHT = `IMG_HEIGHT_DEF
) (
  input  wire                      clk,
  input  wire                      reset_n,
  input  wire scroll_pkg::cfg_regs_t cfg,
  input  wire                      gate_open,
  input  wire                      word_done,
  output logic [31:0]              burst_addr
);

  logic [15:0] col;
  logic [15:0] row;
  logic [15:0] off_x;
  logic [15:0] off_y;
  logic        gate_d;

  logic [16:0] need_x;
  logic [16:0] need_y;
  logic [15:0] clamp_x;
  logic [15:0] clamp_y;
  logic        last_col;
  logic        last_row;
  logic        latch_offsets;

  logic [31:0] y_idx;
  logic [31:0] x_idx;
  logic [31:0] bg_index;

  // Keep the window inside the background
  assign need_x  = {1'b0, cfg.offset_x} + 17'(IMG_WIDTH);
  assign need_y  = {1'b0, cfg.offset_y} + 17'(IMG_HEIGHT);
  assign clamp_x = (need_x > {1'b0, cfg.bg_width}) ?
                   cfg.bg_width - 16'(IMG_WIDTH) : cfg.offset_x;
  assign clamp_y = (need_y > {1'b0, cfg.bg_height}) ?
                   cfg.bg_height - 16'(IMG_HEIGHT) : cfg.offset_y;

  assign last_col = (col == 16'(IMG_WIDTH - 1));
  assign last_row = (row == 16'(IMG_HEIGHT - 1));

  // Frame boundary, or the very first frame
  assign latch_offsets = (word_done && last_col && last_row) || (gate_open && !gate_d);

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      col    <= '0;
      row    <= '0;
      off_x  <= '0;
      off_y  <= '0;
      gate_d <= 1'b0;
    end else begin
      gate_d <= gate_open;
      if (latch_offsets) begin
        off_x <= clamp_x;
        off_y <= clamp_y;
      end
      if (word_done) begin
        if (last_col) begin
          col <= '0;
          row <= last_row ? '0 : row + 16'd1;
        end else begin
          col <= col + 16'd1;
        end
      end
    end
  end

  assign y_idx      = 32'(off_y) + 32'(row);
  assign x_idx      = 32'(off_x) + 32'(col);
  assign bg_index   = y_idx * 32'(cfg.bg_width) + x_idx;
  assign burst_addr = `BG_BASE_ADDR + {bg_index[29:0], 2'b00};

  // Latched window stays inside the background while fetching
  window_inside_bg: assert property (
    @(posedge clk) disable iff (!reset_n)
    gate_d |-> (32'(off_x) + IMG_WIDTH <= 32'(cfg.bg_width))
  );

endmodule

`default_nettype wire

// File: src/burst_read_master.sv
`default_nettype none

`include "scroll_cfg.svh"

module burst_read_master #(
  parameter int INIT_CYCLES = `INIT_CYCLES_DEF
) (
  input  wire                                 clk,
  input  wire                                 reset_n,
  input  wire                                 pll_locked,
  input  wire                                 start,
  input  wire [31:0]                          burst_addr,
  output logic                                gate_open,
  output scroll_pkg::avm_cmd_t                avm_cmd,
  input  wire scroll_pkg::avm_rsp_t           avm_rsp,
  output logic                                word_done,
  output logic                                fifo_push,
  output logic [31:0]                         fifo_wdata,
  input  wire [$clog2(`FIFO_DEPTH + 1) - 1:0] fifo_used
);

  localparam int CNT_W  = $clog2(INIT_CYCLES + 2);
  localparam int BEAT_W = $clog2(`BURST_LEN);

  typedef enum logic [1:0] {
    S_IDLE,
    S_CHECK,
    S_REQ,
    S_RECV
  } state_t;

  state_t              state;
  state_t              nstate;
  logic [CNT_W-1:0]    settle_cnt;
  logic                settled;
  logic [BEAT_W-1:0]   beat_cnt;
  logic                last_beat;
  logic                space_ok;

  // Restarts whenever lock drops
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      settle_cnt <= '0;
    end else if (!pll_locked) begin
      settle_cnt <= '0;
    end else if (!settled) begin
      settle_cnt <= settle_cnt + 1'b1;
    end
  end

  assign settled = (settle_cnt == CNT_W'(INIT_CYCLES));

  // Once open the engine runs for good
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      gate_open <= 1'b0;
    end else if (settled && start) begin
      gate_open <= 1'b1;
    end
  end

  // Reserve a whole burst of FIFO space before asking
  assign space_ok  = (int'(fifo_used) + `BURST_LEN <= `FIFO_DEPTH);
  assign last_beat = (beat_cnt == BEAT_W'(`BURST_LEN - 1));
  assign fifo_push = (state == S_RECV) && avm_rsp.readdatavalid;

  always_comb begin
    nstate = state;
    case (state)
      S_IDLE:  if (gate_open) nstate = S_CHECK;
      S_CHECK: if (space_ok) nstate = S_REQ;
      S_REQ:   if (!avm_rsp.waitrequest) nstate = S_RECV;
      S_RECV:  if (fifo_push && last_beat) nstate = S_CHECK;
      default: nstate = S_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      state    <= S_IDLE;
      beat_cnt <= '0;
    end else begin
      state <= nstate;
      if (state == S_REQ) begin
        beat_cnt <= '0;
      end else if (fifo_push) begin
        beat_cnt <= beat_cnt + 1'b1;
      end
    end
  end

  assign avm_cmd.read       = (state == S_REQ);
  assign avm_cmd.address    = burst_addr;
  assign avm_cmd.burstcount = 5'(`BURST_LEN);

  assign word_done  = fifo_push;
  assign fifo_wdata = avm_rsp.readdata;

  cmd_held_while_waiting: assert property (
    @(posedge clk) disable iff (!reset_n)
    avm_cmd.read && avm_rsp.waitrequest |=> avm_cmd.read && $stable(avm_cmd.address)
  );

  no_data_outside_burst: assert property (
    @(posedge clk) disable iff (!reset_n)
    avm_rsp.readdatavalid |-> state == S_RECV
  );

  no_push_into_full_fifo: assert property (
    @(posedge clk) disable iff (!reset_n)
    fifo_push |-> int'(fifo_used) < `FIFO_DEPTH
  );

endmodule

`default_nettype wire

// File: src/pixel_fifo.sv
`default_nettype none

`include "scroll_cfg.svh"

module pixel_fifo #(
  parameter int DEPTH = `FIFO_DEPTH
) (
  input  wire                           clk,
  input  wire                           reset_n,
  input  wire                           push,
  input  wire [31:0]                    wdata,
  input  wire                           pop,
  output logic [31:0]                   rdata,
  output logic                          empty,
  output logic [$clog2(DEPTH + 1) - 1:0] used
);

  localparam int AW = $clog2(DEPTH);
  localparam int UW = $clog2(DEPTH + 1);

  logic [31:0]   mem [DEPTH];
  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic          do_push;
  logic          do_pop;

  assign empty   = (used == '0);
  assign do_pop  = pop && !empty;
  assign do_push = push && ((used != UW'(DEPTH)) || do_pop);

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= wdata;
    end
  end

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      used   <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   used <= used + 1'b1;
        2'b01:   used <= used - 1'b1;
        default: used <= used;
      endcase
    end
  end

  // Show-ahead head word
  assign rdata = mem[rd_ptr];

  pop_only_when_data: assert property (
    @(posedge clk) disable iff (!reset_n)
    pop |-> !empty
  );

endmodule

`default_nettype wire

// File: src/bg_fetch_top.sv
`default_nettype none

`include "scroll_cfg.svh"

module bg_fetch_top #(
  parameter int IMG_WIDTH   = `IMG_WIDTH_DEF,
  parameter int IMG_HEIGHT  = `IMG_HEIGHT_DEF,
  parameter int INIT_CYCLES = `INIT_CYCLES_DEF
) (
  input  wire                       clk,
  input  wire                       reset_n,
  input  wire scroll_pkg::csr_wr_t  csr,
  input  wire                       pll_locked,
  output scroll_pkg::avm_cmd_t      avm_cmd,
  input  wire scroll_pkg::avm_rsp_t avm_rsp,
  output logic [31:0]               pix_data,
  output logic                      pix_empty,
  input  wire                       pix_rd
);

  import scroll_pkg::*;

  cfg_regs_t                          cfg;
  logic [31:0]                        burst_addr;
  logic                               gate_open;
  logic                               word_done;
  logic                               fifo_push;
  logic [31:0]                        fifo_wdata;
  logic [$clog2(`FIFO_DEPTH + 1)-1:0] fifo_used;

  scroll_regs u_regs (
    .clk     (clk),
    .reset_n (reset_n),
    .csr     (csr),
    .cfg     (cfg)
  );

  viewport_addr_gen #(
    .IMG_WIDTH  (IMG_WIDTH),
    .IMG_HEIGHT (IMG_HEIGHT)
  ) u_addr_gen (
    .clk        (clk),
    .reset_n    (reset_n),
    .cfg        (cfg),
    .gate_open  (gate_open),
    .word_done  (word_done),
    .burst_addr (burst_addr)
  );

  burst_read_master #(
    .INIT_CYCLES (INIT_CYCLES)
  ) u_master (
    .clk        (clk),
    .reset_n    (reset_n),
    .pll_locked (pll_locked),
    .start      (cfg.start),
    .burst_addr (burst_addr),
    .gate_open  (gate_open),
    .avm_cmd    (avm_cmd),
    .avm_rsp    (avm_rsp),
    .word_done  (word_done),
    .fifo_push  (fifo_push),
    .fifo_wdata (fifo_wdata),
    .fifo_used  (fifo_used)
  );

  pixel_fifo #(
    .DEPTH (`FIFO_DEPTH)
  ) u_fifo (
    .clk     (clk),
    .reset_n (reset_n),
    .push    (fifo_push),
    .wdata   (fifo_wdata),
    .pop     (pix_rd),
    .rdata   (pix_data),
    .empty   (pix_empty),
    .used    (fifo_used)
  );

endmodule

`default_nettype wire

// File: sim/sdram_model.sv
`default_nettype none

module sdram_model #(
  parameter int WAIT_PCT = 30,
  parameter int MAX_GAP  = 6
) (
  input  wire                       clk,
  input  wire                       reset_n,
  input  wire scroll_pkg::avm_cmd_t avm_cmd,
  output scroll_pkg::avm_rsp_t      avm_rsp
);

  import scroll_pkg::*;

  logic        busy;
  logic [31:0] base_addr;
  logic [4:0]  beat;
  logic [4:0]  beats;
  logic [3:0]  gap;

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      avm_rsp   <= '0;
      busy      <= 1'b0;
      base_addr <= '0;
      beat      <= '0;
      beats     <= '0;
      gap       <= '0;
    end else begin
      avm_rsp.waitrequest   <= ($urandom_range(99) < WAIT_PCT);
      avm_rsp.readdatavalid <= 1'b0;
      if (!busy) begin
        if (avm_cmd.read && !avm_rsp.waitrequest) begin
          busy      <= 1'b1;
          base_addr <= avm_cmd.address;
          beat      <= '0;
          beats     <= avm_cmd.burstcount;
          gap       <= 4'($urandom_range(MAX_GAP));
        end
      end else if (gap != 4'd0) begin
        gap <= gap - 4'd1;
      end else begin
        avm_rsp.readdatavalid <= 1'b1;
        avm_rsp.readdata      <= (base_addr ^ 32'hA5A5_0000) + 32'(beat) * 32'd4;
        beat                  <= beat + 5'd1;
        // occasional hole between beats
        gap                   <= ($urandom_range(3) == 0) ? 4'd1 : 4'd0;
        if (beat == beats - 5'd1) begin
          busy <= 1'b0;
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: sim/tb_bg_fetch.sv
`default_nettype none

`include "scroll_cfg.svh"

module tb_bg_fetch;

  import scroll_pkg::*;

  localparam int W = 16;
  localparam int H = 8;
  localparam int BG_W = 64;
  localparam int BG_H = 32;
  localparam int FRAME = W * H;
  localparam int LIMIT = 20000;

  logic        clk;
  logic        reset_n;
  logic        pll_locked;
  logic        pix_rd;
  logic        pix_empty;
  logic [31:0] pix_data;
  csr_wr_t     csr;
  avm_cmd_t    avm_cmd;
  avm_rsp_t    avm_rsp;
  logic        prev_hold;
  logic [31:0] prev_addr;
  logic [31:0] popped [$];
  logic [31:0] frame [FRAME];
  int          pop_pct;
  int          cur_x;
  int          cur_y;
  int          test_errs;
  int          errors;
  int          checks;
  int          tests_run;
  int          tests_failed;
  int          port_errs;

  bg_fetch_top #(.IMG_WIDTH(W), .IMG_HEIGHT(H), .INIT_CYCLES(20)) uut (
    .clk        (clk),
    .reset_n    (reset_n),
    .csr        (csr),
    .pll_locked (pll_locked),
    .avm_cmd    (avm_cmd),
    .avm_rsp    (avm_rsp),
    .pix_data   (pix_data),
    .pix_empty  (pix_empty),
    .pix_rd     (pix_rd)
  );

  sdram_model u_mem (
    .clk     (clk),
    .reset_n (reset_n),
    .avm_cmd (avm_cmd),
    .avm_rsp (avm_rsp)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // Display side pops at most every other cycle so a pop never meets an empty FIFO
  always @(posedge clk) begin
    if (!reset_n) begin
      pix_rd <= 1'b0;
    end else begin
      if (pix_rd) begin
        popped.push_back(pix_data);
      end
      pix_rd <= !pix_empty && !pix_rd && ($urandom_range(99) < pop_pct);
    end
  end

  // Memory port rules
  always @(posedge clk) begin
    if (reset_n) begin
      if (prev_hold && (!avm_cmd.read || avm_cmd.address != prev_addr)) begin
        $display("read command changed while waitrequest was high");
        port_errs++;
      end
      if (avm_cmd.read && avm_cmd.burstcount != `BURST_LEN) begin
        $display("FAILED burstcount: expected %0d actual %0d", `BURST_LEN, avm_cmd.burstcount);
        port_errs++;
      end
      if (avm_cmd.read && avm_cmd.address[1:0] != 2'b00) begin
        $display("read address %h is not word aligned", avm_cmd.address);
        port_errs++;
      end
    end
    prev_hold <= reset_n && avm_cmd.read && avm_rsp.waitrequest;
    prev_addr <= avm_cmd.address;
  end

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("*** FAILED ***");
    $finish;
  endtask

  task automatic write_reg(input logic [2:0] addr, input int data);
    @(posedge clk);
    csr <= '{write: 1'b1, address: addr, writedata: 32'(data)};
    @(posedge clk);
    csr <= '0;
  endtask

  task automatic wait_words(input int count, input string name);
    int waited;
    waited = 0;
    while (popped.size() < count && waited < LIMIT) begin
      @(posedge clk);
      waited++;
    end
    if (popped.size() < count) begin
      abort_run($sformatf("timeout in %s waiting for pixels", name));
    end
  endtask

  task automatic expect_idle(input string name, input int cycles);
    repeat (cycles) begin
      @(posedge clk);
      checks++;
      if (avm_cmd.read !== 1'b0 || pix_empty !== 1'b1) begin
        $display("FAILED %s: expected read 0 empty 1 actual read %b empty %b",
                 name, avm_cmd.read, pix_empty);
        test_errs++;
      end
    end
  endtask

  // Memory word = burst byte address ^ A5A50000, plus 4 per beat
  function automatic logic [31:0] expected_pixel(input int ox, input int oy, input int idx);
    int          col;
    logic [31:0] addr;
    col  = idx % W;
    addr = `BG_BASE_ADDR + 32'(((oy + idx / W) * BG_W + ox + col - col % `BURST_LEN) * 4);
    return (addr ^ 32'hA5A5_0000) + 32'((col % `BURST_LEN) * 4);
  endfunction

  function automatic int clamp_offset(input int off, input int span, input int bg);
    return (off + span > bg) ? bg - span : off;
  endfunction

  function automatic int first_mismatch(input int ox, input int oy);
    for (int i = 0; i < FRAME; i++) begin
      if (frame[i] !== expected_pixel(ox, oy, i)) begin
        return i;
      end
    end
    return -1;
  endfunction

  // Next frame must match offsets (ox, oy) or the alternative (ax, ay)
  task automatic check_frame(input string name, input int ox, input int oy,
                             input int ax, input int ay);
    int bad;
    wait_words(FRAME, name);
    for (int i = 0; i < FRAME; i++) begin
      frame[i] = popped.pop_front();
    end
    bad = first_mismatch(ox, oy);
    checks++;
    if (bad >= 0 && first_mismatch(ax, ay) >= 0) begin
      $display("FAILED %s word %0d: expected %h actual %h",
               name, bad, expected_pixel(ox, oy, bad), frame[bad]);
      test_errs++;
    end
  endtask

  task automatic end_test(input string name);
    tests_run++;
    errors += test_errs;
    if (test_errs == 0) begin
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: %0d errors", name, test_errs);
    end
    test_errs = 0;
  endtask

  task automatic offset_change(input string name, input int wr_x, input int wr_y);
    int new_x;
    int new_y;
    new_x = clamp_offset(wr_x, W, BG_W);
    new_y = clamp_offset(wr_y, H, BG_H);
    // Mid frame so the fetch side has not reached the frame end yet
    wait_words(40, name);
    write_reg(3'd2, wr_x);
    write_reg(3'd3, wr_y);
    check_frame(name, cur_x, cur_y, cur_x, cur_y);
    check_frame(name, new_x, new_y, cur_x, cur_y);
    check_frame(name, new_x, new_y, new_x, new_y);
    cur_x = new_x;
    cur_y = new_y;
    end_test(name);
  endtask

  initial begin
    void'($urandom(14));
    reset_n      = 1'b0;
    pll_locked   = 1'b0;
    pix_rd       = 1'b0;
    csr          = '0;
    pop_pct      = 50;
    cur_x        = 0;
    cur_y        = 0;
    test_errs    = 0;
    errors       = 0;
    checks       = 0;
    tests_run    = 0;
    tests_failed = 0;
    port_errs    = 0;
    repeat (4) @(posedge clk);
    reset_n <= 1'b1;

    write_reg(3'd0, BG_W);
    write_reg(3'd1, BG_H);
    write_reg(3'd2, 0);
    write_reg(3'd3, 0);
    expect_idle("startup_gate", 30);
    // Locked and settled, start still clear
    pll_locked <= 1'b1;
    expect_idle("startup_gate", 50);
    // Start set while the lock is lost
    pll_locked <= 1'b0;
    write_reg(3'd4, 1);
    expect_idle("startup_gate", 30);
    // Settling count restarts with the new lock
    pll_locked <= 1'b1;
    expect_idle("startup_gate", 20);
    check_frame("startup_gate", 0, 0, 0, 0);
    end_test("startup_gate");

    check_frame("plain_fetch", 0, 0, 0, 0);
    check_frame("plain_fetch", 0, 0, 0, 0);
    end_test("plain_fetch");

    offset_change("clamping", 60, 30);
    offset_change("frame_update", 8, 4);

    pop_pct = 8;
    check_frame("back_pressure", cur_x, cur_y, cur_x, cur_y);
    check_frame("back_pressure", cur_x, cur_y, cur_x, cur_y);
    test_errs += port_errs;
    end_test("back_pressure");

    $display("tests run %0d, failed %0d, checks %0d, errors %0d",
             tests_run, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+include
src/scroll_pkg.sv
src/scroll_regs.sv
src/viewport_addr_gen.sv
src/burst_read_master.sv
src/pixel_fifo.sv
src/bg_fetch_top.sv
sim/sdram_model.sv
sim/tb_bg_fetch.sv

// File: Bender.yml
package:
  name: bg_fetch

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - src/scroll_pkg.sv
      - src/scroll_regs.sv
      - src/viewport_addr_gen.sv
      - src/burst_read_master.sv
      - src/pixel_fifo.sv
      - src/bg_fetch_top.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - sim/sdram_model.sv
      - sim/tb_bg_fetch.sv
